// ==== mem_sub_consts.svh ====
`ifndef MEM_SUB_CONSTS_SVH
`define MEM_SUB_CONSTS_SVH

`default_nettype none

// Request index width shared by all three channels
`define MEM_INDEX_W 19

`define MEM_WORD_W 64               // Data word and write mask width

`define MEM_BURST_LEN 8             // Words in one instruction line

`define MEM_LATENCY 4               // Accept to first word in cycles with a minimum of two

`define MEM_DEPTH_LOG2 10           // Default number of decoded index bits

`default_nettype wire

`endif

// ==== mem_sub_pkg.sv ====
`include "mem_sub_consts.svh"
`default_nettype none

package mem_sub_pkg;

    // Word index as seen by every channel
    typedef logic [`MEM_INDEX_W-1:0] index_t;

    // One memory word, also the shape of the per-bit write mask
    typedef logic [`MEM_WORD_W-1:0] word_t;

    // Instruction line with element 0 in the lowest bits
    typedef logic [`MEM_BURST_LEN-1:0][`MEM_WORD_W-1:0] line_t;

endpackage : mem_sub_pkg

`default_nettype wire

// ==== channel_arb.sv ====
`timescale 1ns/100ps
`include "mem_sub_consts.svh"
`default_nettype none

module channel_arb (
    input  wire                  pc_index_valid,          // Fetch request pending
    input  wire mem_sub_pkg::index_t pc_index,            // Fetch index before line alignment
    output logic                 pc_index_ready,          // Fetch granted this cycle

    input  wire                  opstore_index_valid,     // Store request pending
    input  wire mem_sub_pkg::index_t opstore_index,
    input  wire mem_sub_pkg::word_t  opstore_write_mask,  // Set bits get replaced
    input  wire mem_sub_pkg::word_t  opstore_write_data,
    output logic                 opstore_index_ready,     // Store granted this cycle

    input  wire                  opload_index_valid,      // Load request pending
    input  wire mem_sub_pkg::index_t opload_index,
    output logic                 opload_index_ready,      // Load granted this cycle

    input  wire                  ddr_ready,               // Controller idle
    output logic                 ddr_chip_enable,         // One-cycle accept strobe
    output mem_sub_pkg::index_t  ddr_index,
    output logic                 ddr_write_enable,        // High only for a store
    output logic                 ddr_burst_mode,          // High only for a fetch
    output mem_sub_pkg::word_t   ddr_opstore_write_mask,
    output mem_sub_pkg::word_t   ddr_opstore_write_data
);
    import mem_sub_pkg::*;

    always_comb begin
        ddr_chip_enable        = 1'b0;                    // Idle port unless a grant below
        ddr_index              = '0;
        ddr_write_enable       = 1'b0;
        ddr_burst_mode         = 1'b0;
        ddr_opstore_write_mask = '0;
        ddr_opstore_write_data = '0;
        pc_index_ready         = 1'b0;
        opstore_index_ready    = 1'b0;
        opload_index_ready     = 1'b0;

        if (ddr_ready) begin                              // No grants while busy
            if (opstore_index_valid) begin                // Store wins over everything
                opstore_index_ready    = 1'b1;
                ddr_chip_enable        = 1'b1;
                ddr_index              = opstore_index;
                ddr_write_enable       = 1'b1;
                ddr_opstore_write_mask = opstore_write_mask;
                ddr_opstore_write_data = opstore_write_data;
            end else if (opload_index_valid) begin        // Then the single-word load
                opload_index_ready     = 1'b1;
                ddr_chip_enable        = 1'b1;
                ddr_index              = opload_index;
            end else if (pc_index_valid) begin            // Fetch only when data side is quiet
                pc_index_ready         = 1'b1;
                ddr_chip_enable        = 1'b1;
                ddr_index              = pc_index;
                ddr_burst_mode         = 1'b1;
            end
        end
    end

    // Grant checks on the combinational outputs
    always_comb begin
        assert ($onehot0({pc_index_ready, opstore_index_ready, opload_index_ready}))
            else $error("channel_arb: more than one channel granted");
        assert (!(ddr_chip_enable && !ddr_ready))
            else $error("channel_arb: chip enable raised while memory busy");
    end

endmodule : channel_arb

`default_nettype wire

// ==== mem_ctrl.sv ====
`timescale 1ns/100ps
`include "mem_sub_consts.svh"
`default_nettype none

module mem_ctrl (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      ddr_chip_enable,        // Accept strobe
    input  wire mem_sub_pkg::index_t ddr_index,
    input  wire                      ddr_write_enable,
    input  wire                      ddr_burst_mode,         // Eight-word line read
    input  wire mem_sub_pkg::word_t  ddr_opstore_write_mask,
    input  wire mem_sub_pkg::word_t  ddr_opstore_write_data,
    input  wire mem_sub_pkg::word_t  array_rdata,            // Valid one cycle after a read
    output logic                     ddr_ready,
    output logic                     ddr_operation_done,     // One-cycle pulse
    output mem_sub_pkg::word_t       ddr_opload_read_data,   // Valid with done
    output mem_sub_pkg::line_t       ddr_pc_read_inst,       // Valid with done
    output logic                     array_en,
    output logic                     array_we,
    output mem_sub_pkg::index_t      array_addr,
    output mem_sub_pkg::word_t       array_mask,
    output mem_sub_pkg::word_t       array_wdata
);
    import mem_sub_pkg::*;

    localparam int CNT_W  = $clog2(`MEM_LATENCY + `MEM_BURST_LEN + 1);
    localparam int BEAT_W = $clog2(`MEM_BURST_LEN);
    localparam logic [CNT_W-1:0] FIRST_CNT      = CNT_W'(`MEM_LATENCY - 1);
    localparam logic [CNT_W-1:0] BURST_LAST_CNT = CNT_W'(`MEM_LATENCY + `MEM_BURST_LEN - 2);

    logic             busy_q;                 // Operation in progress
    logic [CNT_W-1:0] cnt_q;                  // Cycles since accept
    logic             done_q;
    logic             rvalid_q;               // Array returns a word this cycle
    logic             op_we_q;                // Latched operation fields
    logic             op_burst_q;
    index_t           op_index_q;
    word_t            op_mask_q;
    word_t            op_data_q;
    line_t            line_q;                 // Burst words shift in from the top
    logic [CNT_W-1:0] last_cnt;
    logic             in_window;
    logic             last_access;
    logic [BEAT_W-1:0] beat;
    index_t           line_base;

    assign last_cnt    = op_burst_q ? BURST_LAST_CNT : FIRST_CNT;
    assign in_window   = busy_q && (cnt_q >= FIRST_CNT) && (cnt_q <= last_cnt);
    assign last_access = in_window && (cnt_q == last_cnt);
    assign beat        = BEAT_W'(cnt_q - FIRST_CNT);                 // Word within the line
    assign line_base   = op_index_q & ~index_t'(`MEM_BURST_LEN - 1); // Line-aligned start

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q   <= 1'b0;
            cnt_q    <= '0;
            done_q   <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            done_q   <= last_access;                   // Lines up with the last read word
            rvalid_q <= in_window && !op_we_q;
            if (ddr_chip_enable) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(1);
            end else if (done_q) begin
                busy_q <= 1'b0;                        // Ready again the cycle after done
            end else if (busy_q) begin
                cnt_q  <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ddr_chip_enable) begin
            op_we_q    <= ddr_write_enable;
            op_burst_q <= ddr_burst_mode;
            op_index_q <= ddr_index;
            op_mask_q  <= ddr_opstore_write_mask;
            op_data_q  <= ddr_opstore_write_data;
        end
        if (rvalid_q) begin
            line_q <= {array_rdata, line_q[`MEM_BURST_LEN-1:1]};
        end
    end

    assign ddr_ready            = !busy_q;
    assign ddr_operation_done   = done_q;
    assign ddr_opload_read_data = array_rdata;                            // Word read last cycle
    assign ddr_pc_read_inst     = {array_rdata, line_q[`MEM_BURST_LEN-1:1]}; // Last word on top

    assign array_en    = in_window;
    assign array_we    = in_window && op_we_q;
    assign array_addr  = op_burst_q ? (line_base | index_t'(beat)) : op_index_q;
    assign array_mask  = op_mask_q;
    assign array_wdata = op_data_q;

    a_done_single : assert property (@(posedge clk) disable iff (reset)
        ddr_operation_done |=> !ddr_operation_done)
        else $error("mem_ctrl: done held longer than one cycle");

    a_no_accept_busy : assert property (@(posedge clk) disable iff (reset)
        ddr_chip_enable |-> !busy_q)
        else $error("mem_ctrl: operation offered while busy");

    // Accept to done spacing seen from the port
    a_word_latency : assert property (@(posedge clk) disable iff (reset)
        ddr_chip_enable && !ddr_burst_mode |-> ##(`MEM_LATENCY) ddr_operation_done)
        else $error("mem_ctrl: word operation done out of time");

endmodule : mem_ctrl

`default_nettype wire

// ==== mem_array.sv ====
`timescale 1ns/100ps
`include "mem_sub_consts.svh"
`default_nettype none

module mem_array #(
    parameter int depth_log2 = `MEM_DEPTH_LOG2       // Decoded index bits
) (
    input  wire                      clk,
    input  wire                      array_en,      // Access this cycle
    input  wire                      array_we,      // Write when high, read otherwise
    input  wire mem_sub_pkg::index_t array_addr,    // Upper bits ignored
    input  wire mem_sub_pkg::word_t  array_mask,
    input  wire mem_sub_pkg::word_t  array_wdata,
    output mem_sub_pkg::word_t       array_rdata    // Registered word held until the next read
);
    import mem_sub_pkg::*;

    localparam int DEPTH = 2 ** depth_log2;

    word_t                 mem_q [DEPTH];
    logic [depth_log2-1:0] word_addr;

    if (depth_log2 < 1 || depth_log2 > `MEM_INDEX_W) begin : g_bad_depth
        $error("mem_array: depth_log2 out of range");
    end

    assign word_addr = array_addr[depth_log2-1:0];

    always_ff @(posedge clk) begin
        if (array_en && array_we) begin
            // Per-bit merge of old and new word
            mem_q[word_addr] <= (mem_q[word_addr] & ~array_mask) | (array_wdata & array_mask);
        end
        if (array_en && !array_we) begin
            array_rdata <= mem_q[word_addr];
        end
    end

endmodule : mem_array

`default_nettype wire

// ==== read_return.sv ====
`timescale 1ns/100ps
`include "mem_sub_consts.svh"
`default_nettype none

module read_return #(
    parameter type payload_t = mem_sub_pkg::word_t   // Load word or fetch line
) (
    input  wire           clk,
    input  wire           reset,
    input  wire           index_valid,               // Channel request
    input  wire           index_ready,               // Channel grant
    input  wire           ddr_operation_done,        // Shared done from the controller
    input  wire payload_t in_data,                   // Valid with ddr done
    output payload_t      read_data,                 // Held until the next capture
    output logic          operation_done             // This channel only
);
    import mem_sub_pkg::*;

    logic armed_q;                                   // Our read is the one in flight
    logic handshake;

    assign handshake = index_valid && index_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            armed_q        <= 1'b0;
            operation_done <= 1'b0;
            read_data      <= '0;
        end else begin
            operation_done <= ddr_operation_done && armed_q;
            if (ddr_operation_done && armed_q) begin
                read_data <= in_data;
                armed_q   <= 1'b0;
            end else if (handshake) begin
                armed_q   <= 1'b1;
            end
        end
    end

    // Only one operation is ever in flight
    a_no_double_arm : assert property (@(posedge clk) disable iff (reset)
        handshake |-> !armed_q)
        else $error("read_return: second grant while a read is pending");

endmodule : read_return

`default_nettype wire

// ==== mem_sub_top.sv ====
`timescale 1ns/100ps
`include "mem_sub_consts.svh"
`default_nettype none

module mem_sub_top #(
    parameter int depth_log2 = `MEM_DEPTH_LOG2
) (
    input  wire                      clk,
    input  wire                      reset,

    input  wire                      pc_index_valid,
    input  wire mem_sub_pkg::index_t pc_index,
    output logic                     pc_index_ready,
    output mem_sub_pkg::line_t       pc_read_inst,
    output logic                     pc_operation_done,

    input  wire                      opstore_index_valid,
    input  wire mem_sub_pkg::index_t opstore_index,
    input  wire mem_sub_pkg::word_t  opstore_write_mask,
    input  wire mem_sub_pkg::word_t  opstore_write_data,
    output logic                     opstore_index_ready,
    output logic                     opstore_operation_done,   // Straight from the controller

    input  wire                      opload_index_valid,
    input  wire mem_sub_pkg::index_t opload_index,
    output logic                     opload_index_ready,
    output mem_sub_pkg::word_t       opload_read_data,
    output logic                     opload_operation_done
);
    import mem_sub_pkg::*;

    logic   ddr_chip_enable;                 // Arbiter to controller
    index_t ddr_index;
    logic   ddr_write_enable;
    logic   ddr_burst_mode;
    word_t  ddr_opstore_write_mask;
    word_t  ddr_opstore_write_data;
    logic   ddr_ready;
    logic   ddr_operation_done;              // Controller to return stages
    word_t  ddr_opload_read_data;
    line_t  ddr_pc_read_inst;
    logic   array_en;                        // Controller to storage
    logic   array_we;
    index_t array_addr;
    word_t  array_mask;
    word_t  array_wdata;
    word_t  array_rdata;

    assign opstore_operation_done = ddr_operation_done;

    channel_arb i_channel_arb (
        .pc_index_valid, .pc_index, .pc_index_ready,
        .opstore_index_valid, .opstore_index, .opstore_write_mask, .opstore_write_data,
        .opstore_index_ready,
        .opload_index_valid, .opload_index, .opload_index_ready,
        .ddr_ready, .ddr_chip_enable, .ddr_index, .ddr_write_enable, .ddr_burst_mode,
        .ddr_opstore_write_mask, .ddr_opstore_write_data
    );

    mem_ctrl i_mem_ctrl (
        .clk, .reset,
        .ddr_chip_enable, .ddr_index, .ddr_write_enable, .ddr_burst_mode,
        .ddr_opstore_write_mask, .ddr_opstore_write_data, .array_rdata,
        .ddr_ready, .ddr_operation_done, .ddr_opload_read_data, .ddr_pc_read_inst,
        .array_en, .array_we, .array_addr, .array_mask, .array_wdata
    );

    mem_array #(.depth_log2(depth_log2)) i_mem_array (
        .clk, .array_en, .array_we, .array_addr, .array_mask, .array_wdata, .array_rdata
    );

    read_return #(.payload_t(word_t)) i_load_return (     // Load word path
        .clk, .reset,
        .index_valid        (opload_index_valid),
        .index_ready        (opload_index_ready),
        .ddr_operation_done,
        .in_data            (ddr_opload_read_data),
        .read_data          (opload_read_data),
        .operation_done     (opload_operation_done)
    );

    read_return #(.payload_t(line_t)) i_fetch_return (    // Instruction line path
        .clk, .reset,
        .index_valid        (pc_index_valid),
        .index_ready        (pc_index_ready),
        .ddr_operation_done,
        .in_data            (ddr_pc_read_inst),
        .read_data          (pc_read_inst),
        .operation_done     (pc_operation_done)
    );

endmodule : mem_sub_top

`default_nettype wire

// ==== tb_mem_sub.sv ====
`timescale 1ns/100ps
`include "mem_sub_consts.svh"
`default_nettype none

module tb_mem_sub;
    import mem_sub_pkg::*;

    localparam int SW        = `MEM_DEPTH_LOG2;              // Index bits the array decodes
    localparam int LIMIT     = 40;                           // Cycles allowed for any one wait
    localparam int LAT_FETCH = `MEM_LATENCY + `MEM_BURST_LEN - 1;
    localparam logic [1:0] CH_STORE = 2'd0;
    localparam logic [1:0] CH_LOAD  = 2'd1;
    localparam logic [1:0] CH_FETCH = 2'd2;

    logic        clk;
    logic        reset;
    logic        pc_index_valid, pc_index_ready, pc_operation_done;
    index_t      pc_index;
    line_t       pc_read_inst;
    logic        opstore_index_valid, opstore_index_ready, opstore_operation_done;
    index_t      opstore_index;
    word_t       opstore_write_mask, opstore_write_data;
    logic        opload_index_valid, opload_index_ready, opload_operation_done;
    index_t      opload_index;
    word_t       opload_read_data;
    word_t       shadow [2**SW];                             // Shadow copy of the storage
    word_t       exp_load;                                   // Taken from the shadow at grant
    line_t       exp_line;
    logic        mem_busy;                                   // Grant seen and done not yet
    logic [31:0] lfsr_q;
    logic [2:0]  readys, valids, dones, grants;              // Bit number is the channel

    assign readys = {pc_index_ready, opload_index_ready, opstore_index_ready};
    assign valids = {pc_index_valid, opload_index_valid, opstore_index_valid};
    assign dones  = {pc_operation_done, opload_operation_done, opstore_operation_done};
    assign grants = readys & valids;

    mem_sub_top i_mem_sub_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                               // 10 ns period
    end

    task automatic abort_run(input string text);
        $display("%s", text);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("FAIL %0t: %s", $time, msg));
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};      // Taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output word_t bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            bits   = {bits[`MEM_WORD_W-2:0], lfsr_q[0]};    // One step per bit
        end
    endtask

    function automatic word_t apply_store(input word_t old, input word_t data,
                                          input word_t mask);
        word_t result;
        result = old;
        for (int b = 0; b < `MEM_WORD_W; b++) begin
            if (mask[b]) begin
                result[b] = data[b];                         // Set mask bit takes the new bit
            end
        end
        return result;
    endfunction

    function automatic line_t line_from_shadow(input index_t idx);
        line_t         result;
        logic [SW-1:0] base;
        result = '0;
        base   = idx[SW-1:0] & ~SW'(`MEM_BURST_LEN - 1);    // Line-aligned start
        for (int w = 0; w < `MEM_BURST_LEN; w++) begin
            result[w] = shadow[base + SW'(w)];               // Word w of the line
        end
        return result;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_busy <= 1'b0;
        end else if (grants != 3'b000) begin
            mem_busy <= 1'b1;
        end else if (opstore_operation_done) begin
            mem_busy <= 1'b0;                                // Broadcast done frees the memory
        end
        if (grants[CH_STORE]) begin                          // Set mask bits take the new data
            shadow[opstore_index[SW-1:0]] <= apply_store(shadow[opstore_index[SW-1:0]],
                                                         opstore_write_data,
                                                         opstore_write_mask);
        end
        if (grants[CH_LOAD]) exp_load <= shadow[opload_index[SW-1:0]];
        if (grants[CH_FETCH]) exp_line <= line_from_shadow(pc_index);
    end

    a_one_grant : assert property (@(posedge clk) disable iff (reset) $onehot0(readys))
        else report_mismatch("more than one channel granted");
    a_priority : assert property (@(posedge clk) disable iff (reset)
        readys == grants && !(readys[CH_LOAD] && opstore_index_valid)
        && !(readys[CH_FETCH] && (opstore_index_valid || opload_index_valid)))
        else report_mismatch("grant broke the store, load, fetch order");
    a_grant_idle : assert property (@(posedge clk) disable iff (reset)
        !mem_busy && valids != 3'b000 |-> readys != 3'b000)
        else report_mismatch("idle memory left a request without ready");
    a_busy_hold : assert property (@(posedge clk) disable iff (reset)
        mem_busy |-> readys == 3'b000) else report_mismatch("ready given while busy");
    a_store_time : assert property (@(posedge clk) disable iff (reset)
        grants[CH_STORE] |-> ##(`MEM_LATENCY) opstore_operation_done)
        else report_mismatch("store done out of time");
    a_load_time : assert property (@(posedge clk) disable iff (reset)
        grants[CH_LOAD] |-> ##(`MEM_LATENCY + 1) opload_operation_done)
        else report_mismatch("load done out of time");
    a_fetch_time : assert property (@(posedge clk) disable iff (reset)
        grants[CH_FETCH] |-> ##(LAT_FETCH + 1) pc_operation_done)
        else report_mismatch("fetch done out of time");
    a_no_stray : assert property (@(posedge clk) disable iff (reset)
        (!opload_operation_done || $past(grants[CH_LOAD], `MEM_LATENCY + 1))
        && (!pc_operation_done || $past(grants[CH_FETCH], LAT_FETCH + 1)))
        else report_mismatch("channel done without a matching grant");
    a_load_data : assert property (@(posedge clk) disable iff (reset)
        opload_operation_done |-> opload_read_data == exp_load)
        else report_mismatch($sformatf("load %h, expected %h", opload_read_data, exp_load));
    a_fetch_data : assert property (@(posedge clk) disable iff (reset)
        pc_operation_done |-> pc_read_inst == exp_line)
        else report_mismatch("fetch line differs from the shadow memory");
    a_held : assert property (@(posedge clk) disable iff (reset)
        (opload_operation_done || $stable(opload_read_data))
        && (pc_operation_done || $stable(pc_read_inst)))
        else report_mismatch("returned data changed without a done");

    task automatic request(input logic [1:0] ch, input index_t idx, input word_t mask,
                           input word_t data);
        int waited;
        waited = 0;
        if (ch == CH_STORE) begin
            opstore_index       = idx;
            opstore_write_mask  = mask;
            opstore_write_data  = data;
            opstore_index_valid = 1'b1;
        end else if (ch == CH_LOAD) begin
            opload_index       = idx;
            opload_index_valid = 1'b1;
        end else begin
            pc_index       = idx;
            pc_index_valid = 1'b1;
        end
        @(negedge clk);
        while (!readys[ch]) begin                            // Fields stay steady meanwhile
            if (waited == LIMIT) begin
                abort_run($sformatf("Timeout waiting for a grant on channel %0d", ch));
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);                                      // Handshake edge
        #1;
        if (ch == CH_STORE) opstore_index_valid = 1'b0;
        else if (ch == CH_LOAD) opload_index_valid = 1'b0;
        else pc_index_valid = 1'b0;
    endtask

    task automatic wait_done(input logic [1:0] ch);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!dones[ch]) begin
            if (waited == LIMIT) begin
                abort_run($sformatf("Timeout waiting for done on channel %0d", ch));
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        word_t      mask;
        word_t      data;
        word_t      bits;
        logic [1:0] ch;
        lfsr_q              = 32'h3238;
        reset               = 1'b1;
        pc_index_valid      = 1'b0;
        pc_index            = '0;
        opstore_index_valid = 1'b0;
        opstore_index       = '0;
        opstore_write_mask  = '0;
        opstore_write_data  = '0;
        opload_index_valid  = 1'b0;
        opload_index        = '0;
        ch                  = CH_STORE;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        assert (readys == 3'b000 && dones == 3'b000 && opload_read_data == '0
                && pc_read_inst == '0)
            else report_mismatch("outputs not idle after reset");
        @(posedge clk);
        #1;
        for (int a = 0; a < 2**SW; a++) begin                // Every word read later is written
            request(CH_STORE, index_t'(a), '1, {~32'(a), 32'(a) * 32'h9e37_79b9});
        end
        wait_done(CH_STORE);
        take_bits(`MEM_WORD_W, mask);
        take_bits(`MEM_WORD_W, data);
        request(CH_STORE, 19'h4_0123, mask, data);           // Upper index bits are ignored
        request(CH_LOAD, 19'h0_0123, '0, '0);
        wait_done(CH_LOAD);
        fork                                                 // All three valids at once
            request(CH_STORE, 19'h0_0200, mask, ~data);
            request(CH_LOAD, 19'h0_0200, '0, '0);
            request(CH_FETCH, 19'h0_0205, '0, '0);
        join
        wait_done(CH_FETCH);
        request(CH_FETCH, 19'h1_2345, '0, '0);
        wait_done(CH_FETCH);
        for (int n = 0; n < 300; n++) begin                  // Mixed traffic
            take_bits(2, bits);
            ch = (bits[1:0] == 2'd3) ? CH_STORE : bits[1:0];
            take_bits(`MEM_INDEX_W, bits);
            take_bits(`MEM_WORD_W, mask);
            take_bits(`MEM_WORD_W, data);
            request(ch, bits[`MEM_INDEX_W-1:0], mask, data);
        end
        wait_done(ch);
        $display("TEST OK");
        $finish;
    end

endmodule : tb_mem_sub

`default_nettype wire

// ==== mem_sub.f ====
+incdir+.
mem_sub_pkg.sv
channel_arb.sv
mem_ctrl.sv
mem_array.sv
read_return.sv
mem_sub_top.sv
tb_mem_sub.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --top-module tb_mem_sub -f mem_sub.f
	./obj_dir/Vtb_mem_sub 2>&1 | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" sim.log; then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
